/* logic/uno_defs.svh */
`ifndef UNO_DEFS_SVH
`define UNO_DEFS_SVH

// hand size and cursor index of the draw slot
`define UNO_HAND_MAX      16
`define UNO_IDX_W         5
`define UNO_SCORE_W       11
`define UNO_INIT_DRAW     7

// card values 0..9 are numbers
`define UNO_VALUE_ACTION  10 // skip, reverse, draw two
`define UNO_VALUE_WILD    13
`define UNO_VALUE_WILD4   14

`define UNO_ACTION_POINTS 20
`define UNO_WILD_POINTS   50

// unused slot
`define UNO_EMPTY_CARD    6'b111111

`endif

/* logic/uno_pkg.sv */
package uno_pkg;

    `include "uno_defs.svh"

    typedef logic [1:0] color_t; // red, yellow, green, blue
    typedef logic [3:0] value_t;

    typedef struct packed {
        color_t color;
        value_t value;
    } card_t;

    typedef logic [`UNO_IDX_W-1:0]   hand_idx_t;
    typedef logic [`UNO_SCORE_W-1:0] score_t;

    typedef enum logic [2:0] {
        IDLE,
        DRAW,
        PLAY,
        NOCARD,
        CHECK,
        CHOOSE,
        OUT
    } turn_state_e;

    typedef enum logic [1:0] {
        STAY,
        HELD,  // waiting for button release
        COLOR
    } cursor_state_e;

endpackage

/* logic/hand_cursor.sv */
`timescale 1ns/1ps
`include "uno_defs.svh"

module hand_cursor
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_left,
    input  logic      i_right,
    input  logic      i_color_mode,
    input  hand_idx_t i_hand_num,
    output hand_idx_t o_index
);

    cursor_state_e state;
    logic          held_left;  // which button we wait on
    hand_idx_t     index;
    hand_idx_t     last_idx;
    hand_idx_t     draw_slot;
    hand_idx_t     left_idx;
    hand_idx_t     right_idx;
    hand_idx_t     color_left;
    hand_idx_t     color_right;

    assign draw_slot = hand_idx_t'(`UNO_HAND_MAX);
    assign last_idx  = i_hand_num - 1'b1;

    // hand mode wraps through the draw slot
    always_comb begin
        if (i_hand_num == '0) begin
            left_idx  = draw_slot;
            right_idx = draw_slot;
        end else begin
            if (index == '0)
                left_idx = draw_slot;
            else if (index == draw_slot)
                left_idx = last_idx;
            else
                left_idx = index - 1'b1;

            if (index == last_idx)
                right_idx = draw_slot;
            else if (index == draw_slot)
                right_idx = '0;
            else
                right_idx = index + 1'b1;
        end
    end

    // colour mode wraps over 0..3
    assign color_left  = (index == '0) ? hand_idx_t'(3) : index - 1'b1;
    assign color_right = (index == hand_idx_t'(3)) ? '0 : index + 1'b1;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= STAY;
            held_left <= 1'b0;
            index     <= '0;
        end else begin
            case (state)
                STAY: begin
                    if (i_color_mode) begin
                        index <= '0;
                        state <= COLOR;
                    end else if (i_left) begin
                        index     <= left_idx;
                        held_left <= 1'b1;
                        state     <= HELD;
                    end else if (i_right) begin
                        index     <= right_idx;
                        held_left <= 1'b0;
                        state     <= HELD;
                    end else if (i_hand_num == '0 && index != draw_slot) begin
                        index <= draw_slot; // nothing to point at
                    end else if (index > last_idx && index != draw_slot) begin
                        index <= last_idx;  // hand shrank
                    end
                end
                HELD: begin
                    if (held_left ? !i_left : !i_right)
                        state <= i_color_mode ? COLOR : STAY;
                end
                COLOR: begin
                    if (!i_color_mode) begin
                        index <= '0;
                        state <= STAY;
                    end else if (i_left) begin
                        index     <= color_left;
                        held_left <= 1'b1;
                        state     <= HELD;
                    end else if (i_right) begin
                        index     <= color_right;
                        held_left <= 1'b0;
                        state     <= HELD;
                    end
                end
                default: state <= STAY;
            endcase
        end
    end

    assign o_index = index;

endmodule

/* logic/hand_store.sv */
`timescale 1ns/1ps
`include "uno_defs.svh"

module hand_store
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_append,
    input  card_t     i_append_card,
    input  logic      i_remove,
    input  hand_idx_t i_index,
    output card_t     o_sel_card,
    output hand_idx_t o_hand_num,
    output logic      o_add,
    output logic      o_sub,
    output card_t     o_score_card
);

    card_t     slots [`UNO_HAND_MAX];
    hand_idx_t count;
    logic      append_ok;
    logic      remove_ok;
    logic      index_in_range;

    // a full hand drops the new card
    assign append_ok      = i_append && (count < hand_idx_t'(`UNO_HAND_MAX));
    assign remove_ok      = i_remove && (i_index < count);
    assign index_in_range = i_index < hand_idx_t'(`UNO_HAND_MAX);

    // draw slot reads as an empty card
    assign o_sel_card = index_in_range ? slots[i_index[3:0]] : card_t'(`UNO_EMPTY_CARD);
    assign o_hand_num = count;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count <= '0;
            for (int i = 0; i < `UNO_HAND_MAX; i++) begin
                slots[i] <= card_t'(`UNO_EMPTY_CARD);
            end
        end else if (append_ok) begin
            slots[count[3:0]] <= i_append_card;
            count             <= count + 1'b1;
        end else if (remove_ok) begin
            // close the gap, keep arrival order
            for (int i = 0; i < `UNO_HAND_MAX - 1; i++) begin
                if (i >= i_index)
                    slots[i] <= slots[i+1];
            end
            slots[`UNO_HAND_MAX-1] <= card_t'(`UNO_EMPTY_CARD);
            count                  <= count - 1'b1;
        end
    end

    // score update follows the hand by one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_add <= 1'b0;
            o_sub <= 1'b0;
        end else begin
            o_add <= append_ok;
            o_sub <= !append_ok && remove_ok;
        end
    end

    always_ff @(posedge i_clk) begin
        if (append_ok)
            o_score_card <= i_append_card;
        else if (remove_ok)
            o_score_card <= o_sel_card; // card leaving the hand
    end

endmodule

/* logic/turn_fsm.sv */
`timescale 1ns/1ps
`include "uno_defs.svh"

module turn_fsm
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_init,
    input  logic      i_start,
    input  logic      i_draw_two,
    input  logic      i_draw_four,
    input  logic      i_select,
    input  logic      i_drawn,
    input  card_t     i_drawn_card,
    input  logic      i_check,
    input  card_t     i_prev_card,
    input  hand_idx_t i_index,
    input  card_t     i_sel_card,
    output logic      o_append,
    output card_t     o_append_card,
    output logic      o_remove,
    output logic      o_color_mode,
    output logic      o_out,
    output logic      o_draw,
    output card_t     o_out_card
);

    turn_state_e state;
    turn_state_e state_nx;
    logic [2:0]  pending;     // cards still to draw
    logic [2:0]  pending_nx;
    logic        armed;       // select released inside CHOOSE
    logic        on_draw_slot;
    logic        real_card;
    logic        is_wild;
    logic        is_legal;
    logic        pick_wild;
    logic        pick_card;
    logic        pick_color;

    assign on_draw_slot = (i_index == hand_idx_t'(`UNO_HAND_MAX));
    assign real_card    = (i_sel_card != card_t'(`UNO_EMPTY_CARD));
    assign is_wild      = (i_sel_card.value == value_t'(`UNO_VALUE_WILD)) ||
                          (i_sel_card.value == value_t'(`UNO_VALUE_WILD4));
    assign is_legal     = (i_sel_card.color == i_prev_card.color) ||
                          (i_sel_card.value == i_prev_card.value);

    assign pick_wild  = (state == PLAY) && i_select && !on_draw_slot && real_card && is_wild;
    assign pick_card  = (state == PLAY) && i_select && !on_draw_slot && real_card &&
                        !is_wild && is_legal;
    assign pick_color = (state == CHOOSE) && armed && i_select;

    always_comb begin
        state_nx   = state;
        pending_nx = pending;
        case (state)
            IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        state_nx   = DRAW;
                        pending_nx = 3'd2;
                    end else if (i_draw_four) begin
                        state_nx   = DRAW;
                        pending_nx = 3'd4;
                    end else begin
                        state_nx = PLAY;
                    end
                end else if (i_init) begin
                    state_nx   = DRAW;
                    pending_nx = 3'(`UNO_INIT_DRAW);
                end
            end
            DRAW: begin
                if (i_drawn) begin
                    pending_nx = pending - 1'b1;
                    if (pending <= 3'd1)
                        state_nx = i_start ? PLAY : IDLE;
                end
            end
            PLAY: begin
                if (i_select && on_draw_slot)
                    state_nx = NOCARD;
                else if (pick_wild)
                    state_nx = CHOOSE;
                else if (pick_card)
                    state_nx = OUT;
            end
            NOCARD:  if (i_drawn) state_nx = CHECK;
            CHECK:   if (i_check) state_nx = IDLE;
            CHOOSE:  if (pick_color) state_nx = OUT;
            OUT:     if (i_check) state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= IDLE;
            pending    <= '0;
            armed      <= 1'b0;
            o_out_card <= '0;
        end else begin
            state   <= state_nx;
            pending <= pending_nx;
            armed   <= (state == CHOOSE) && (armed || !i_select);
            if (pick_wild || pick_card)
                o_out_card <= i_sel_card;
            else if (pick_color)
                o_out_card.color <= color_t'(i_index[1:0]); // keeps the wild value
        end
    end

    assign o_append      = i_drawn && (state == DRAW || state == NOCARD);
    assign o_append_card = i_drawn_card;
    assign o_remove      = pick_wild || pick_card;
    assign o_color_mode  = (state == CHOOSE);
    assign o_out         = (state == OUT);
    assign o_draw        = (state == NOCARD);

endmodule

/* logic/score_keeper.sv */
`timescale 1ns/1ps
`include "uno_defs.svh"

module score_keeper
    import uno_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst_n,
    input  logic   i_add,
    input  logic   i_sub,
    input  card_t  i_card,
    output score_t o_score
);

    score_t points;
    score_t score;

    function automatic score_t card_points(input card_t card);
        if (card.value >= value_t'(`UNO_VALUE_WILD))
            return score_t'(`UNO_WILD_POINTS);
        else if (card.value >= value_t'(`UNO_VALUE_ACTION))
            return score_t'(`UNO_ACTION_POINTS);
        else
            return score_t'(card.value); // number cards count face value
    endfunction

    assign points = card_points(i_card);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            score <= '0;
        else if (i_add)
            score <= score + points;
        else if (i_sub)
            score <= score - points;
    end

    assign o_score = score;

endmodule

/* logic/uno_player.sv */
`timescale 1ns/1ps

module uno_player
    import uno_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_init,
    input  logic      i_start,
    input  logic      i_draw_two,
    input  logic      i_draw_four,
    input  logic      i_left,
    input  logic      i_right,
    input  logic      i_select,
    input  card_t     i_prev_card,
    input  logic      i_drawn,
    input  card_t     i_drawn_card,
    input  logic      i_check,
    output logic      o_out,
    output card_t     o_out_card,
    output logic      o_draw,
    output hand_idx_t o_index,
    output hand_idx_t o_hand_num,
    output score_t    o_score
);

    hand_idx_t index;
    hand_idx_t hand_num;
    logic      color_mode;
    logic      append;
    card_t     append_card;
    logic      remove;
    card_t     sel_card;
    logic      score_add;
    logic      score_sub;
    card_t     score_card;

    hand_cursor u_cursor (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_color_mode (color_mode),
        .i_hand_num   (hand_num),
        .o_index      (index)
    );

    turn_fsm u_fsm (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_init        (i_init),
        .i_start       (i_start),
        .i_draw_two    (i_draw_two),
        .i_draw_four   (i_draw_four),
        .i_select      (i_select),
        .i_drawn       (i_drawn),
        .i_drawn_card  (i_drawn_card),
        .i_check       (i_check),
        .i_prev_card   (i_prev_card),
        .i_index       (index),
        .i_sel_card    (sel_card),
        .o_append      (append),
        .o_append_card (append_card),
        .o_remove      (remove),
        .o_color_mode  (color_mode),
        .o_out         (o_out),
        .o_draw        (o_draw),
        .o_out_card    (o_out_card)
    );

    hand_store u_store (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_append      (append),
        .i_append_card (append_card),
        .i_remove      (remove),
        .i_index       (index),
        .o_sel_card    (sel_card),
        .o_hand_num    (hand_num),
        .o_add         (score_add),
        .o_sub         (score_sub),
        .o_score_card  (score_card)
    );

    score_keeper u_score (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_add   (score_add),
        .i_sub   (score_sub),
        .i_card  (score_card),
        .o_score (o_score)
    );

    assign o_index    = index;
    assign o_hand_num = hand_num;

endmodule

/* test/tb_uno_model.svh */
`ifndef TB_UNO_MODEL_SVH
`define TB_UNO_MODEL_SVH

card_t     hand_q[$];   // hand in arrival order
score_t    exp_score;
hand_idx_t exp_idx;
logic      exp_color;   // colour choice active

function automatic logic wild_card(input card_t c);
    return (c.value == value_t'(`UNO_VALUE_WILD)) || (c.value == value_t'(`UNO_VALUE_WILD4));
endfunction

function automatic score_t point_value(input card_t c);
    if (wild_card(c))
        return score_t'(`UNO_WILD_POINTS);
    if (c.value >= value_t'(`UNO_VALUE_ACTION))
        return score_t'(`UNO_ACTION_POINTS); // skip, reverse, draw two
    return score_t'(c.value);
endfunction

function automatic logic legal_play(input card_t c, input card_t prev);
    return (c.color == prev.color) || (c.value == prev.value);
endfunction

task automatic model_clamp();
    if (hand_q.size() == 0)
        exp_idx = hand_idx_t'(`UNO_HAND_MAX);
    else if (exp_idx != hand_idx_t'(`UNO_HAND_MAX) && int'(exp_idx) > hand_q.size() - 1)
        exp_idx = hand_idx_t'(hand_q.size() - 1);
endtask

task automatic model_append(input card_t c);
    if (hand_q.size() < `UNO_HAND_MAX) begin  // full hand drops it
        hand_q.push_back(c);
        exp_score = exp_score + point_value(c);
    end
endtask

task automatic model_remove(input int pos);
    exp_score = exp_score - point_value(hand_q[pos]);
    hand_q.delete(pos);
    model_clamp();
endtask

// one cursor step with the hand wrap through the draw slot
function automatic hand_idx_t next_index(input hand_idx_t idx, input logic left,
                                         input int count, input logic colour);
    hand_idx_t draw;
    hand_idx_t last;
    draw = hand_idx_t'(`UNO_HAND_MAX);
    last = hand_idx_t'(count - 1);
    if (colour)
        return left ? ((idx == 0) ? hand_idx_t'(3) : idx - 1'b1)
                    : ((idx == 3) ? hand_idx_t'(0) : idx + 1'b1);
    if (count == 0)
        return draw;
    if (left)
        return (idx == 0) ? draw : ((idx == draw) ? last : idx - 1'b1);
    return (idx == last) ? draw : ((idx == draw) ? hand_idx_t'(0) : idx + 1'b1);
endfunction

`endif

/* test/tb_uno_player.sv */
`timescale 1ns/1ps
`include "uno_defs.svh"

module tb_uno_player
    import uno_pkg::*;
();

    localparam int DEAL_CYC   = 80;
    localparam int CURSOR_CYC = 12 * 10;
    localparam int PLAY_CYC   = 3 * (17 * 10 + 60);
    localparam int WILD_CYC   = 17 * 10 + 40 + 4 * 10 + 60;
    localparam int PENAL_CYC  = 2 * (40 + 17 * 10 + 90);
    localparam int FULL_CYC   = 2 * 60;
    localparam int LIMIT      = DEAL_CYC + CURSOR_CYC + PLAY_CYC + WILD_CYC +
                                PENAL_CYC + FULL_CYC + 300;

    logic i_clk, i_rst_n, i_init, i_start, i_draw_two, i_draw_four;
    logic i_left, i_right, i_select, i_drawn, i_check;
    card_t i_prev_card, i_drawn_card, o_out_card;
    logic o_out, o_draw;
    hand_idx_t o_index, o_hand_num;
    score_t o_score;

    logic [31:0] lfsr;
    int errors;
    int checks;
    int err_mark;
    int tests;

    `include "tb_uno_model.svh"

    uno_player UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic card_t rand_card();
        card_t c;
        c.color = color_t'(rand_bits(2));
        c.value = value_t'(rand_bits(4));
        if (c.value == 4'hf)
            c.value = 4'h0; // no such card
        return c;
    endfunction

    task automatic check_card(input string name, input card_t got, input card_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input hand_idx_t got, input hand_idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_score(input string name, input score_t got, input score_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wait_flag(input logic want_draw);
        int n;
        n = 0;
        @(negedge i_clk);
        while ((want_draw ? !o_draw : !o_out) && n < 20) begin
            @(negedge i_clk);
            n++;
        end
        if (want_draw ? !o_draw : !o_out) begin
            errors++;
            $display("%s never went high at %0t", want_draw ? "o_draw" : "o_out", $time);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task automatic pulse_check();
        @(posedge i_clk) i_check <= 1'b1;
        @(posedge i_clk) i_check <= 1'b0;
        repeat (2) @(posedge i_clk);
    endtask

    task automatic draw_card(input card_t c);
        @(posedge i_clk);
        i_drawn      <= 1'b1;
        i_drawn_card <= c;
        @(posedge i_clk) i_drawn <= 1'b0;
        model_append(c);
    endtask

    task automatic check_hand();
        @(posedge i_clk);   // score trails the hand by one cycle
        @(negedge i_clk);
        check_idx("o_hand_num", o_hand_num, hand_idx_t'(hand_q.size()));
        check_score("o_score", o_score, exp_score);
    endtask

    task automatic deal(input int n);
        @(posedge i_clk) i_init <= 1'b1;
        @(posedge i_clk) i_init <= 1'b0;
        for (int k = 0; k < n; k++) begin
            repeat (2) @(posedge i_clk);
            draw_card(rand_card());
        end
        check_hand();
    endtask

    task automatic press(input logic left);
        int hold;
        hold = 1 + int'(rand_bits(2)) % 3;
        @(posedge i_clk);
        if (left)
            i_left <= 1'b1;
        else
            i_right <= 1'b1;
        repeat (hold) @(posedge i_clk);
        i_left  <= 1'b0;
        i_right <= 1'b0;
        repeat (2) @(posedge i_clk);
        exp_idx = next_index(exp_idx, left, hand_q.size(), exp_color);
        @(negedge i_clk);
        check_idx("o_index", o_index, exp_idx);
    endtask

    task automatic move_to(input hand_idx_t t);
        while (exp_idx != t)
            press(1'b0);
    endtask

    task automatic pulse_select();
        @(posedge i_clk) i_select <= 1'b1;
        @(posedge i_clk) i_select <= 1'b0;
    endtask

    task automatic play_round();
        int t;
        card_t c;
        card_t prev;
        t = -1;
        for (int k = 0; k < hand_q.size(); k++)
            if (t < 0 && !wild_card(hand_q[k]))
                t = k;
        if (t < 0)
            return;
        move_to(hand_idx_t'(t));
        c = hand_q[t];
        prev = rand_card();
        if (rand_bits(1))
            prev.color = c.color;
        @(posedge i_clk);
        i_prev_card <= prev;
        i_start     <= 1'b1;
        @(posedge i_clk) i_start <= 1'b0;
        if (!legal_play(c, prev)) begin
            pulse_select();
            repeat (5) begin
                @(negedge i_clk);
                check_bit("o_out", o_out, 1'b0);
                check_idx("o_hand_num", o_hand_num, hand_idx_t'(hand_q.size()));
            end
            @(posedge i_clk) i_prev_card <= c; // now a match
        end
        pulse_select();
        wait_flag(1'b0);
        check_card("o_out_card", o_out_card, c);
        model_remove(t);
        check_hand();
        pulse_check();
    endtask

    task automatic penalty_draw(input int n, input logic wild_first);
        card_t c;
        @(posedge i_clk);
        i_start <= 1'b1;
        if (n == 2)
            i_draw_two <= 1'b1;
        else
            i_draw_four <= 1'b1;
        @(posedge i_clk);
        i_draw_two  <= 1'b0;
        i_draw_four <= 1'b0;
        for (int k = 0; k < n; k++) begin
            c = rand_card();
            if (wild_first && k == 0)
                c.value = rand_bits(1) ? value_t'(`UNO_VALUE_WILD4) : value_t'(`UNO_VALUE_WILD);
            repeat (2) @(posedge i_clk);
            draw_card(c);
        end
        @(posedge i_clk) i_start <= 1'b0; // FSM is now in PLAY
        check_hand();
    endtask

    task automatic wild_test();
        int t;
        card_t w;
        penalty_draw(2, 1'b1);
        t = hand_q.size() - 2;
        w = hand_q[t];
        move_to(hand_idx_t'(t));
        @(posedge i_clk) i_select <= 1'b1;
        @(posedge i_clk);
        @(posedge i_clk) i_select <= 1'b0;
        model_remove(t);
        exp_color = 1'b1;
        exp_idx   = '0;
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        check_idx("o_index", o_index, exp_idx);
        repeat (int'(rand_bits(2))) press(lfsr_bit());
        w.color = color_t'(exp_idx[1:0]);
        pulse_select();
        wait_flag(1'b0);
        check_card("o_out_card", o_out_card, w);
        check_hand();
        exp_color = 1'b0;
        exp_idx   = '0;
        model_clamp();
        pulse_check();
        @(negedge i_clk);
        check_idx("o_index", o_index, exp_idx);
    endtask

    task automatic nocard_test(input int n);
        card_t c;
        penalty_draw(n, 1'b0);
        move_to(hand_idx_t'(`UNO_HAND_MAX));
        pulse_select();
        wait_flag(1'b1);
        c = rand_card();
        if (wild_card(c))
            c.value = value_t'(`UNO_VALUE_ACTION); // played back below
        repeat (3) begin
            @(negedge i_clk);
            check_bit("o_draw", o_draw, 1'b1);  // holds until a card comes
        end
        draw_card(c);
        check_hand();
        check_bit("o_draw", o_draw, 1'b0);
        pulse_check();
        // new card sits just left of the draw slot
        @(posedge i_clk);
        i_prev_card <= c;
        i_start     <= 1'b1;
        @(posedge i_clk) i_start <= 1'b0;
        press(1'b1);
        pulse_select();
        wait_flag(1'b0);
        check_card("o_out_card", o_out_card, c);
        model_remove(hand_q.size() - 1);
        check_hand();
        pulse_check();
    endtask

    initial begin
        int n;
        n = 0;
        while (n < LIMIT) begin
            @(posedge i_clk);
            n++;
        end
        $display("timeout: no result after %0d cycles", LIMIT);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        lfsr = 32'hd9cf6295;
        errors = 0;
        checks = 0;
        err_mark = 0;
        tests = 0;
        exp_score = '0;
        exp_idx = hand_idx_t'(`UNO_HAND_MAX); // empty hand parks on the draw slot
        exp_color = 1'b0;
        i_rst_n = 1'b0;
        i_init = 1'b0;
        i_start = 1'b0;
        i_draw_two = 1'b0;
        i_draw_four = 1'b0;
        i_left = 1'b0;
        i_right = 1'b0;
        i_select = 1'b0;
        i_drawn = 1'b0;
        i_check = 1'b0;
        i_prev_card = '0;
        i_drawn_card = '0;
        repeat (4) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2) @(posedge i_clk);

        deal(`UNO_INIT_DRAW);
        end_test("deal");
        repeat (12) press(lfsr_bit());
        end_test("cursor");
        repeat (3) play_round();
        end_test("play");
        wild_test();
        end_test("wild");
        nocard_test(2);
        nocard_test(4);
        end_test("penalty");
        deal(`UNO_INIT_DRAW);
        deal(`UNO_INIT_DRAW);
        check_idx("o_hand_num", o_hand_num, hand_idx_t'(`UNO_HAND_MAX));
        end_test("full hand");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* list.f */
+incdir+logic
+incdir+test
logic/uno_pkg.sv
logic/hand_cursor.sv
logic/hand_store.sv
logic/turn_fsm.sv
logic/score_keeper.sv
logic/uno_player.sv
test/tb_uno_player.sv

/* run.sh */
#!/bin/sh
# build and run the testbench, result decided from the log
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_uno_player -o sim_uno \
    && ./obj_dir/sim_uno > sim.log \
    && grep -q "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
